/* Makefile */
# Verilator build and run of the decode slice testbench

OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tbDecodeCore \
		-f project.f --Mdir $(OBJDIR) -o simv
	./$(OBJDIR)/simv > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "TEST FAILED, no result"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJDIR) sim.log

/* cpu_consts.svh */
// Width constants shared by the 16-bit decode slice
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Register and result width
`define DATA_WIDTH 16

// Instruction word width
`define INSTR_WIDTH 16

// Register index width
`define REG_ADDR_WIDTH 3

// Register count, one per index value
`define NUM_REGS 8

`endif

/* decodeControl.sv */
// Opcode decoder producing the control levels for one instruction
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeControl (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output isaPkg::aluOpT           aluOp,
    output isaPkg::destSelT         destSel,
    output logic                    useImm,
    output logic                    zeroExt,
    output logic                    regWrite,
    output logic                    isHalt,
    output logic                    illegal
);

    import isaPkg::*;

    opcodeT opcode;
    rFuncT  func;

    assign opcode = opcodeT'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign func   = rFuncT'(instr[FUNC_MSB:FUNC_LSB]);

    always_comb begin
        aluOp    = ALU_ADD;
        destSel  = DEST_RT;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        regWrite = 1'b0;
        isHalt   = 1'b0;
        illegal  = 1'b0;

        case (opcode)
            OP_HALT: isHalt = 1'b1;
            // Nothing to do
            OP_NOP: ;
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                case (opcode)
                    OP_SUBI: aluOp = ALU_SUB;
                    OP_XORI: aluOp = ALU_XOR;
                    OP_ANDNI: aluOp = ALU_ANDN;
                    default: aluOp = ALU_ADD;
                endcase
                // Logical immediates are unsigned
                zeroExt = (opcode == OP_XORI) || (opcode == OP_ANDNI);
            end
            OP_RTYPE: begin
                destSel  = DEST_RD;
                regWrite = 1'b1;
                case (func)
                    FUNC_ADD: aluOp = ALU_ADD;
                    FUNC_SUB: aluOp = ALU_SUB;
                    FUNC_XOR: aluOp = ALU_XOR;
                    default: aluOp = ALU_ANDN;
                endcase
            end
            OP_LBI: begin
                aluOp    = ALU_PASSB;
                destSel  = DEST_RS;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OP_SLBI: begin
                aluOp    = ALU_SHIFTLOAD;
                destSel  = DEST_RS;
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* decodeCore.sv */
// Top level of the decode slice with decode, two slots, execute and write-back
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeCore (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       instrValid,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    output logic                       wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]     wbData,
    output logic                       illegalInstr,
    output logic                       halted
);

    import pipePkg::*;

    logic decValid;
    logic exValid;
    logic resValid;
    logic wbSlotValid;
    idExT decPayload;
    idExT exPayload;
    exWbT resPayload;
    exWbT wbPayload;

    decodeStage decodeStage_inst (
        .clk       (clk),
        .arstN     (arstN),
        .instrValid(instrValid),
        .instr     (instr),
        .halted    (halted),
        .wbEn      (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .decValid  (decValid),
        .decPayload(decPayload)
    );

    pipeReg #(.payloadT(idExT)) idExSlot (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (decValid),
        .inPayload (decPayload),
        .outValid  (exValid),
        .outPayload(exPayload)
    );

    executeStage executeStage_inst (
        .clk       (clk),
        .arstN     (arstN),
        .exValid   (exValid),
        .exPayload (exPayload),
        .fwdValid  (wbSlotValid),
        .fwdPayload(wbPayload),
        .resValid  (resValid),
        .resPayload(resPayload),
        .halted    (halted)
    );

    pipeReg #(.payloadT(exWbT)) exWbSlot (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (resValid),
        .inPayload (resPayload),
        .outValid  (wbSlotValid),
        .outPayload(wbPayload)
    );

    // Write-back port that also drives the register file write
    assign wbValid      = wbSlotValid && wbPayload.regWrite;
    assign wbReg        = wbPayload.destReg;
    assign wbData       = wbPayload.result;
    assign illegalInstr = wbSlotValid && wbPayload.illegal;

endmodule

/* decodeStage.sv */
// Decode stage with control decode, immediate forming and operand read
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeStage (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       instrValid,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic                       halted,
    input  logic                       wbEn,
    input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]     wbData,
    output logic                       decValid,
    output pipePkg::idExT              decPayload
);

    import isaPkg::*;
    import pipePkg::*;

    aluOpT                      aluOp;
    destSelT                    destSel;
    logic                       useImm;
    logic                       zeroExt;
    logic                       regWrite;
    logic                       isHalt;
    logic                       illegal;
    logic [`REG_ADDR_WIDTH-1:0] rsIdx;
    logic [`REG_ADDR_WIDTH-1:0] rtIdx;
    logic [`REG_ADDR_WIDTH-1:0] destIdx;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    logic [`DATA_WIDTH-1:0]     imm5;
    logic [`DATA_WIDTH-1:0]     imm;

    decodeControl decodeControl_inst (
        .instr   (instr),
        .aluOp   (aluOp),
        .destSel (destSel),
        .useImm  (useImm),
        .zeroExt (zeroExt),
        .regWrite(regWrite),
        .isHalt  (isHalt),
        .illegal (illegal)
    );

    assign rsIdx = instr[RS_LSB +: `REG_ADDR_WIDTH];
    assign rtIdx = instr[RT_LSB +: `REG_ADDR_WIDTH];

    always_comb begin
        case (destSel)
            DEST_RS: destIdx = rsIdx;
            DEST_RD: destIdx = instr[RD_LSB +: `REG_ADDR_WIDTH];
            default: destIdx = rtIdx;
        endcase
    end

    regFile regFile_inst (
        .clk      (clk),
        .arstN    (arstN),
        .read1Sel (rsIdx),
        .read2Sel (rtIdx),
        .writeSel (wbReg),
        .writeData(wbData),
        .writeEn  (wbEn),
        .read1Data(rsData),
        .read2Data(rtData)
    );

    // 5-bit immediate for the arithmetic forms
    assign imm5 = zeroExt ?
        {{(`DATA_WIDTH-IMM5_WIDTH){1'b0}}, instr[IMM5_WIDTH-1:0]} :
        {{(`DATA_WIDTH-IMM5_WIDTH){instr[IMM5_WIDTH-1]}}, instr[IMM5_WIDTH-1:0]};

    // LBI sign extends the byte and SLBI zero extends it
    always_comb begin
        case (aluOp)
            ALU_PASSB: imm = {{(`DATA_WIDTH-IMM8_WIDTH){instr[IMM8_WIDTH-1]}},
                              instr[IMM8_WIDTH-1:0]};
            ALU_SHIFTLOAD: imm = {{(`DATA_WIDTH-IMM8_WIDTH){1'b0}}, instr[IMM8_WIDTH-1:0]};
            default: imm = imm5;
        endcase
    end

    always_comb begin
        decPayload.aluOp    = aluOp;
        decPayload.rsIndex  = rsIdx;
        decPayload.rtIndex  = rtIdx;
        decPayload.rsData   = rsData;
        decPayload.rtData   = rtData;
        decPayload.useImm   = useImm;
        decPayload.imm      = imm;
        decPayload.destReg  = destIdx;
        decPayload.regWrite = regWrite;
        decPayload.isHalt   = isHalt;
        decPayload.illegal  = illegal;
    end

    // Strobes after a halt are dropped
    assign decValid = instrValid && !halted;

    instrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        instrValid |-> !$isunknown(instr)
    );

endmodule

/* executeStage.sv */
// Execute stage with operand forwarding, ALU and halt latch
`timescale 1ns/1ps
`include "cpu_consts.svh"

module executeStage (
    input  logic          clk,
    input  logic          arstN,
    input  logic          exValid,
    input  pipePkg::idExT exPayload,
    input  logic          fwdValid,
    input  pipePkg::exWbT fwdPayload,
    output logic          resValid,
    output pipePkg::exWbT resPayload,
    output logic          halted
);

    import isaPkg::*;
    import pipePkg::*;

    logic                   rsHit;
    logic                   rtHit;
    logic [`DATA_WIDTH-1:0] rsVal;
    logic [`DATA_WIDTH-1:0] rtVal;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   haltQ;

    // Distance-1 dependency takes the value being written back
    assign rsHit = fwdValid && fwdPayload.regWrite && (fwdPayload.destReg == exPayload.rsIndex);
    assign rtHit = fwdValid && fwdPayload.regWrite && (fwdPayload.destReg == exPayload.rtIndex);

    assign rsVal = rsHit ? fwdPayload.result : exPayload.rsData;
    assign rtVal = rtHit ? fwdPayload.result : exPayload.rtData;
    assign opB   = exPayload.useImm ? exPayload.imm : rtVal;

    always_comb begin
        case (exPayload.aluOp)
            ALU_ADD: aluResult = rsVal + opB;
            // Subtract is reversed in this ISA
            ALU_SUB: aluResult = opB - rsVal;
            ALU_XOR: aluResult = rsVal ^ opB;
            ALU_ANDN: aluResult = rsVal & ~opB;
            ALU_PASSB: aluResult = exPayload.imm;
            ALU_SHIFTLOAD: aluResult = (rsVal << IMM8_WIDTH) | exPayload.imm;
            default: aluResult = '0;
        endcase
    end

    always_comb begin
        resPayload.result   = aluResult;
        resPayload.destReg  = exPayload.destReg;
        resPayload.regWrite = exPayload.regWrite;
        resPayload.isHalt   = exPayload.isHalt;
        resPayload.illegal  = exPayload.illegal;
    end

    assign resValid = exValid;

    // Sticky until reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltQ <= 1'b0;
        end else if (resValid && resPayload.isHalt) begin
            haltQ <= 1'b1;
        end
    end

    assign halted = haltQ;

    // Halt holds and nothing new reaches execute after it
    haltSticky: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |=> halted && !exValid
    );

endmodule

/* isaPkg.sv */
// Instruction set encoding of the teaching processor subset
package isaPkg;

    // Major opcode in instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_RTYPE = 5'b11011
    } opcodeT;

    // Operations the execute stage knows
    typedef enum logic [2:0] {
        ALU_ADD       = 3'd0,
        ALU_SUB       = 3'd1,
        ALU_XOR       = 3'd2,
        ALU_ANDN      = 3'd3,
        ALU_PASSB     = 3'd4,
        ALU_SHIFTLOAD = 3'd5
    } aluOpT;

    // Register-type function field in instr[1:0]
    typedef enum logic [1:0] {
        FUNC_ADD  = 2'b00,
        FUNC_SUB  = 2'b01,
        FUNC_XOR  = 2'b10,
        FUNC_ANDN = 2'b11
    } rFuncT;

    // Destination field select among 7:5, 10:8 and 4:2
    typedef enum logic [1:0] {
        DEST_RT = 2'b00,
        DEST_RS = 2'b01,
        DEST_RD = 2'b10
    } destSelT;

    // Field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 11;
    localparam int RS_LSB     = 8;
    localparam int RT_LSB     = 5;
    localparam int RD_LSB     = 2;
    localparam int FUNC_MSB   = 1;
    localparam int FUNC_LSB   = 0;
    localparam int IMM5_WIDTH = 5;
    localparam int IMM8_WIDTH = 8;

endpackage

/* pipePkg.sv */
// Payload types carried by the pipeline slots
`include "cpu_consts.svh"

package pipePkg;

    // Decode to execute
    typedef struct packed {
        isaPkg::aluOpT               aluOp;
        logic [`REG_ADDR_WIDTH-1:0]  rsIndex;
        logic [`REG_ADDR_WIDTH-1:0]  rtIndex;
        logic [`DATA_WIDTH-1:0]      rsData;
        logic [`DATA_WIDTH-1:0]      rtData;
        logic                        useImm;
        logic [`DATA_WIDTH-1:0]      imm;
        logic [`REG_ADDR_WIDTH-1:0]  destReg;
        logic                        regWrite;
        logic                        isHalt;
        logic                        illegal;
    } idExT;

    // Execute to write-back
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]      result;
        logic [`REG_ADDR_WIDTH-1:0]  destReg;
        logic                        regWrite;
        logic                        isHalt;
        logic                        illegal;
    } exWbT;

endpackage

/* pipeReg.sv */
// Pipeline slot holding one payload and its valid bit
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inPayload,
    output logic    outValid,
    output payloadT outPayload
);

    // Valid bit with asynchronous clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Payload captured on every edge
    always_ff @(posedge clk) begin
        outPayload <= inPayload;
    end

endmodule

/* project.f */
+incdir+.
isaPkg.sv
pipePkg.sv
regFile.sv
decodeControl.sv
decodeStage.sv
pipeReg.sv
executeStage.sv
decodeCore.sv
tbDecodeCore.sv

/* regFile.sv */
// Eight-entry register file with two read ports and a bypassed write port
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [`REG_ADDR_WIDTH-1:0] read1Sel,
    input  logic [`REG_ADDR_WIDTH-1:0] read2Sel,
    input  logic [`REG_ADDR_WIDTH-1:0] writeSel,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic                       writeEn,
    output logic [`DATA_WIDTH-1:0]     read1Data,
    output logic [`DATA_WIDTH-1:0]     read2Data
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Same-cycle write shows up on the read side
    always_comb begin
        if (writeEn && (writeSel == read1Sel)) begin
            read1Data = writeData;
        end else begin
            read1Data = regs[read1Sel];
        end

        if (writeEn && (writeSel == read2Sel)) begin
            read2Data = writeData;
        end else begin
            read2Data = regs[read2Sel];
        end
    end

    // Write-back data must be fully resolved
    writeDataKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        writeEn |-> !$isunknown(writeData)
    );

endmodule

/* tbDecodeCore.sv */
// Directed testbench for the decode slice with a reference model and writeback scoreboard
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tbDecodeCore;

    import isaPkg::*;

    // Instructions issued by each test
    localparam int LOAD_COUNT    = 6;
    localparam int IMM_COUNT     = 10;
    localparam int REG_COUNT     = 10;
    localparam int RANDOM_COUNT  = 200;
    localparam int ILLEGAL_COUNT = 8;
    localparam int HALT_COUNT    = 6;
    localparam int TOTAL_COUNT   = LOAD_COUNT + IMM_COUNT + REG_COUNT + RANDOM_COUNT
                                   + ILLEGAL_COUNT + HALT_COUNT;
    localparam int CYCLE_LIMIT   = 40 + 3 * TOTAL_COUNT;

    logic                       clk;
    logic                       arstN;
    logic                       instrValid;
    logic [`INSTR_WIDTH-1:0]    instr;
    logic                       wbValid;
    logic [`REG_ADDR_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0]     wbData;
    logic                       illegalInstr;
    logic                       halted;

    // Reference model state
    logic [`DATA_WIDTH-1:0]     modelRegs [`NUM_REGS];
    logic [`REG_ADDR_WIDTH-1:0] expRegQ [$];
    logic [`DATA_WIDTH-1:0]     expDataQ [$];
    int                         expDueQ [$];
    int                         illDueQ [$];
    int                         haltDue = 32'h7fffffff;
    int                         cycleCount = 0;
    logic [31:0]                rngState = 32'h62c14143;

    decodeCore decodeCore_inst (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .illegalInstr(illegalInstr),
        .halted      (halted)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Cycle counter and run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "Stopped by the cycle limit");
        end
    end

    task automatic reportFailure(input string what);
        $display("ERROR %0t: %s", $time, what);
        $display("Errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Instruction encoders
    function automatic logic [15:0] immForm(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] regForm(input logic [2:0] rs, input logic [2:0] rt,
                                            input logic [2:0] rd, input logic [1:0] func);
        return {OP_RTYPE, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] byteForm(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    // Applies one instruction to the model in program order
    task automatic modelIssue(input logic [15:0] ins);
        logic [4:0]  op;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [2:0]  dest;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] sImm5;
        logic [15:0] zImm5;
        logic [15:0] res;
        logic        writes;
        op     = ins[15:11];
        rs     = ins[10:8];
        rt     = ins[7:5];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        sImm5  = {{11{ins[4]}}, ins[4:0]};
        zImm5  = {11'b0, ins[4:0]};
        dest   = rt;
        res    = '0;
        writes = 1'b1;
        // Strobes from the halt cycle on are dropped
        if (cycleCount < haltDue) begin
            case (op)
                OP_ADDI: res = a + sImm5;
                OP_SUBI: res = sImm5 - a;
                OP_XORI: res = a ^ zImm5;
                OP_ANDNI: res = a & ~zImm5;
                OP_RTYPE: begin
                    dest = ins[4:2];
                    case (ins[1:0])
                        2'b00: res = a + b;
                        2'b01: res = b - a;
                        2'b10: res = a ^ b;
                        default: res = a & ~b;
                    endcase
                end
                OP_LBI: begin
                    dest = rs;
                    res  = {{8{ins[7]}}, ins[7:0]};
                end
                OP_SLBI: begin
                    dest = rs;
                    res  = (a << 8) | {8'h00, ins[7:0]};
                end
                OP_NOP: writes = 1'b0;
                OP_HALT: begin
                    writes  = 1'b0;
                    haltDue = cycleCount + 2;
                end
                default: begin
                    writes = 1'b0;
                    illDueQ.push_back(cycleCount + 2);
                end
            endcase
            if (writes) begin
                modelRegs[dest] = res;
                expRegQ.push_back(dest);
                expDataQ.push_back(res);
                expDueQ.push_back(cycleCount + 2);
            end
        end
    endtask

    task automatic checkWriteback();
        int                         headDue;
        logic [`REG_ADDR_WIDTH-1:0] headReg;
        logic [`DATA_WIDTH-1:0]     headData;
        if (wbValid) begin
            assert (expDueQ.size() > 0)
            else reportFailure($sformatf("writeback to r%0d with none expected", wbReg));
            headDue  = expDueQ.pop_front();
            headReg  = expRegQ.pop_front();
            headData = expDataQ.pop_front();
            assert (headDue == cycleCount)
            else reportFailure($sformatf("writeback in cycle %0d, expected cycle %0d",
                                         cycleCount, headDue));
            assert (wbReg == headReg)
            else reportFailure($sformatf("wbReg %0d, expected %0d", wbReg, headReg));
            assert (wbData == headData)
            else reportFailure($sformatf("wbData %h, expected %h", wbData, headData));
        end else if (expDueQ.size() > 0) begin
            assert (expDueQ[0] > cycleCount)
            else reportFailure($sformatf("no writeback to r%0d in cycle %0d",
                                         expRegQ[0], expDueQ[0]));
        end
    endtask

    task automatic checkIllegal();
        int dropped;
        if (illDueQ.size() > 0 && illDueQ[0] == cycleCount) begin
            assert (illegalInstr === 1'b1)
            else reportFailure("illegalInstr missing for an illegal opcode");
            dropped = illDueQ.pop_front();
        end else begin
            assert (illegalInstr === 1'b0)
            else reportFailure("unexpected illegalInstr pulse");
        end
    endtask

    // Scoreboard samples on the falling edge
    always @(negedge clk) begin
        checkWriteback();
        checkIllegal();
        assert (halted === (cycleCount >= haltDue))
        else reportFailure($sformatf("halted is %b in cycle %0d", halted, cycleCount));
    end

    task automatic issue(input logic [15:0] ins);
        @(negedge clk);
        instrValid = 1'b1;
        instr      = ins;
        modelIssue(ins);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            instrValid = 1'b0;
            instr      = '0;
        end
    endtask

    // Wait until every expected writeback and illegal pulse has been seen
    task automatic drain();
        idle(1);
        while (expDueQ.size() > 0 || illDueQ.size() > 0) begin
            @(negedge clk);
        end
        idle(1);
    endtask

    task automatic testLoadImm();
        issue(byteForm(OP_LBI, 3'd1, 8'h80));
        issue(byteForm(OP_LBI, 3'd2, 8'h7F));
        issue(byteForm(OP_SLBI, 3'd1, 8'hA5));
        issue(byteForm(OP_LBI, 3'd3, 8'hFF));
        issue(byteForm(OP_SLBI, 3'd3, 8'h01));
        issue(byteForm(OP_SLBI, 3'd2, 8'hC3));
        drain();
    endtask

    task automatic testImmArith();
        issue(immForm(OP_ADDI, 3'd1, 3'd4, 5'h0F));
        issue(immForm(OP_ADDI, 3'd2, 3'd5, 5'h10));
        issue(immForm(OP_SUBI, 3'd1, 3'd4, 5'h10));
        issue(immForm(OP_SUBI, 3'd2, 3'd5, 5'h0F));
        issue(immForm(OP_XORI, 3'd3, 3'd6, 5'h1F));
        issue(immForm(OP_XORI, 3'd2, 3'd6, 5'h10));
        issue(immForm(OP_ANDNI, 3'd3, 3'd7, 5'h1F));
        issue(immForm(OP_ANDNI, 3'd1, 3'd7, 5'h10));
        issue(immForm(OP_ADDI, 3'd0, 3'd0, 5'h00));
        issue(immForm(OP_SUBI, 3'd0, 3'd0, 5'h1F));
        drain();
    endtask

    // Dependent chains at distance 1, 2 and 3 into the rd field
    task automatic testRegArith();
        issue(regForm(3'd1, 3'd2, 3'd4, 2'b00));
        issue(regForm(3'd4, 3'd2, 3'd5, 2'b01));
        issue(regForm(3'd5, 3'd4, 3'd6, 2'b10));
        issue(regForm(3'd4, 3'd6, 3'd7, 2'b11));
        issue(regForm(3'd5, 3'd7, 3'd0, 2'b00));
        issue(regForm(3'd0, 3'd0, 3'd1, 2'b01));
        issue(regForm(3'd7, 3'd1, 3'd2, 2'b10));
        issue(regForm(3'd2, 3'd0, 3'd3, 2'b11));
        issue(regForm(3'd3, 3'd3, 3'd3, 2'b00));
        issue(regForm(3'd3, 3'd2, 3'd3, 2'b01));
        drain();
    endtask

    task automatic testRandom();
        logic [4:0] op;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            rngState = xorshift32(rngState);
            case (rngState[3:0])
                4'd0: op = OP_ADDI;
                4'd1: op = OP_SUBI;
                4'd2: op = OP_XORI;
                4'd3: op = OP_ANDNI;
                4'd8, 4'd9: op = OP_LBI;
                4'd10, 4'd11: op = OP_SLBI;
                4'd12: op = OP_NOP;
                default: op = OP_RTYPE;
            endcase
            issue({op, rngState[26:16]});
            // Occasional hole in the strobe
            if (rngState[31:30] == 2'b00) begin
                idle(1);
            end
        end
        drain();
    endtask

    task automatic testIllegal();
        issue(immForm(5'b00010, 3'd4, 3'd4, 5'h03));
        issue(immForm(5'b00100, 3'd4, 3'd4, 5'h07));
        issue(immForm(5'b01100, 3'd5, 3'd4, 5'h11));
        issue(byteForm(5'b10100, 3'd4, 8'h5A));
        issue(byteForm(5'b11100, 3'd4, 8'hA5));
        issue(regForm(3'd4, 3'd4, 3'd4, 2'b00) | 16'hF800);
        // Copies of r4 and r5 show them untouched
        issue(immForm(OP_ADDI, 3'd4, 3'd6, 5'h00));
        issue(immForm(OP_XORI, 3'd5, 3'd7, 5'h00));
        drain();
    endtask

    task automatic testHalt();
        issue(byteForm(OP_LBI, 3'd1, 8'h12));
        issue({OP_HALT, 11'b0});
        issue(immForm(OP_ADDI, 3'd1, 3'd2, 5'h01));
        issue(byteForm(OP_LBI, 3'd3, 8'h55));
        issue(byteForm(OP_LBI, 3'd4, 8'h66));
        issue(regForm(3'd1, 3'd2, 3'd5, 2'b00));
        drain();
        idle(4);
        assert (halted === 1'b1)
        else reportFailure("halted dropped after HALT");
    endtask

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(negedge clk);
        arstN = 1'b1;

        testLoadImm();
        testImmArith();
        testRegArith();
        testRandom();
        testIllegal();
        testHalt();

        $display("No errors");
        $finish;
    end

endmodule
